/* logic/csr_pkg.sv */
// shared CSR numbers, field positions, ecodes and op encoding; TLB, DMW and LLbit numbers are not defined
package csr_pkg;

    localparam int CSR_NUM_W = 14;

    // register numbers
    localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h000;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h001;
    localparam logic [CSR_NUM_W-1:0] CSR_ECFG   = 14'h004;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h005;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h006;
    localparam logic [CSR_NUM_W-1:0] CSR_BADV   = 14'h007;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'h00c;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE0  = 14'h030;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE1  = 14'h031;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE2  = 14'h032;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE3  = 14'h033;
    localparam logic [CSR_NUM_W-1:0] CSR_TID    = 14'h040;
    localparam logic [CSR_NUM_W-1:0] CSR_TCFG   = 14'h041;
    localparam logic [CSR_NUM_W-1:0] CSR_TVAL   = 14'h042;
    localparam logic [CSR_NUM_W-1:0] CSR_TICLR  = 14'h044;

    // field positions
    localparam int CRMD_IE_BIT       = 2;
    localparam int PRMD_PIE_BIT      = 2;
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TICLR_CLR_BIT     = 0;
    localparam int EENTRY_VA_LSB     = 6;   // entry is 64-byte aligned

    // exception codes that load BADV
    localparam logic [5:0] ECODE_ADE     = 6'h08;
    localparam logic [5:0] ECODE_ALE     = 6'h09;
    localparam logic [8:0] ESUBCODE_ADEF = 9'd1;   // fetch side, BADV takes the pc

    localparam logic [12:0] ECFG_LIE_MASK = 13'h1bff;   // bit 10 reserved
    localparam logic [31:0] TIMER_IDLE    = 32'hffff_ffff;

    typedef enum logic [1:0] {
        OP_NONE = 2'd0,
        OP_RD   = 2'd1,
        OP_WR   = 2'd2,
        OP_XCHG = 2'd3
    } csr_op_t;

    // opcode patterns, csr ops carry 8'h04 in bits 31:24
    localparam logic [31:0] INST_CSR_MASK  = 32'hff00_0000;
    localparam logic [31:0] INST_CSR_MATCH = 32'h0400_0000;
    localparam logic [31:0] INST_ERTN      = 32'h0648_3800;

    // bits under mask come from value, the rest keep old
    function automatic logic [31:0] csr_merge(input logic [31:0] old_value,
                                              input logic [31:0] mask,
                                              input logic [31:0] value);
        csr_merge = (mask & value) | (~mask & old_value);
    endfunction

endpackage

/* logic/csr_inst_decode.sv */
// CSR instruction decode; only csrrd/csrwr/csrxchg and ertn are recognized, all else decodes as no op
`timescale 1ns/1ps

module csr_inst_decode import csr_pkg::*; (
    input  logic                 inst_valid,
    input  logic [31:0]          inst,
    output csr_op_t              op,
    output logic [CSR_NUM_W-1:0] csr_num,
    output logic                 ertn
);

    logic       is_csr_inst;
    logic       is_ertn_inst;
    logic [4:0] rj_field;

    assign is_csr_inst  = (inst & INST_CSR_MASK) == INST_CSR_MATCH;
    assign is_ertn_inst = inst == INST_ERTN;
    assign rj_field     = inst[9:5];

    always_comb begin
        op      = OP_NONE;
        ertn    = 1'b0;
        csr_num = inst[10 +: CSR_NUM_W];   // number field sits in bits 23:10

        if (inst_valid && is_csr_inst) begin
            // rj selects the flavour, rj >= 2 names the mask register
            case (rj_field)
                5'd0:    op = OP_RD;
                5'd1:    op = OP_WR;
                default: op = OP_XCHG;
            endcase
        end

        if (inst_valid && is_ertn_inst) begin
            ertn = 1'b1;
        end

        // csr patterns and ertn are disjoint opcodes
        assert (!(op != OP_NONE && ertn))
            else $error("decode: csr op and ertn active together, inst %h", inst);
    end

endmodule

/* logic/csr_file.sv */
// CSR file; unimplemented numbers read zero and drop writes, CRMD translation fields read zero
`timescale 1ns/1ps

module csr_file import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,
    input  csr_op_t              op,
    input  logic [CSR_NUM_W-1:0] csr_num,
    input  logic [31:0]          rj_data,
    input  logic [31:0]          rd_data,
    input  logic                 ertn,
    input  logic                 wb_ex,
    input  logic [5:0]           wb_ecode,
    input  logic [8:0]           wb_esubcode,
    input  logic [31:0]          wb_pc,
    input  logic [31:0]          wb_vaddr,
    input  logic [7:0]           hw_int_in,
    input  logic                 ipi_int_in,
    input  logic [31:0]          timer_rvalue,
    input  logic                 is_timer,
    output logic                 csr_we,
    output logic [31:0]          wmask,
    output logic [31:0]          wvalue,
    output logic [31:0]          rvalue,
    output logic [31:0]          eentry,
    output logic [31:0]          era,
    output logic [12:0]          estat_is,
    output logic [12:0]          ecfg_lie,
    output logic                 crmd_ie
);

    logic [1:0]  crmd_plv;
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    logic [5:0]  estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [31:0] badv;
    logic [31:EENTRY_VA_LSB] eentry_va;
    logic [31:0] save_data [4];
    logic [31:0] tid;

    logic [31:0] crmd_rvalue;
    logic [31:0] prmd_rvalue;
    logic [31:0] ecfg_rvalue;
    logic [31:0] estat_rvalue;
    logic        ticlr_clr;
    logic        badv_load;

    logic [31:0] crmd_wdata;
    logic [31:0] prmd_wdata;
    logic [31:0] ecfg_wdata;
    logic [31:0] estat_wdata;
    logic [31:0] eentry_wdata;

    // a writeback exception cancels the csr write of this cycle
    assign csr_we = (op == OP_WR || op == OP_XCHG) && !wb_ex;
    assign wmask  = (op == OP_XCHG) ? rj_data : 32'hffff_ffff;
    assign wvalue = rd_data;

    assign crmd_rvalue  = {29'b0, crmd_ie, crmd_plv};
    assign prmd_rvalue  = {29'b0, prmd_pie, prmd_pplv};
    assign ecfg_rvalue  = {19'b0, ecfg_lie};
    assign estat_rvalue = {1'b0, estat_esubcode, estat_ecode, 3'b0, estat_is};
    assign eentry       = {eentry_va, {EENTRY_VA_LSB{1'b0}}};

    // merged write data per register
    assign crmd_wdata   = csr_merge(crmd_rvalue, wmask, wvalue);
    assign prmd_wdata   = csr_merge(prmd_rvalue, wmask, wvalue);
    assign ecfg_wdata   = csr_merge(ecfg_rvalue, wmask, wvalue);
    assign estat_wdata  = csr_merge(estat_rvalue, wmask, wvalue);
    assign eentry_wdata = csr_merge(eentry, wmask, wvalue);

    assign ticlr_clr = csr_we && csr_num == CSR_TICLR
                       && wmask[TICLR_CLR_BIT] && wvalue[TICLR_CLR_BIT];
    assign badv_load = wb_ecode == ECODE_ADE || wb_ecode == ECODE_ALE;

    // CRMD and PRMD, exception > ertn > csr write
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv  <= 2'b0;
            crmd_ie   <= 1'b0;
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv  <= 2'b0;       // kernel, interrupts off
            crmd_ie   <= 1'b0;
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && csr_num == CSR_CRMD) begin
            crmd_plv <= crmd_wdata[1:0];
            crmd_ie  <= crmd_wdata[CRMD_IE_BIT];
        end else if (csr_we && csr_num == CSR_PRMD) begin
            prmd_pplv <= prmd_wdata[1:0];
            prmd_pie  <= prmd_wdata[PRMD_PIE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ecfg_lie <= 13'b0;
        end else if (csr_we && csr_num == CSR_ECFG) begin
            ecfg_lie <= ecfg_wdata[12:0] & ECFG_LIE_MASK;
        end
    end

    // interrupt status, sampled every cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_is <= 13'b0;
        end else begin
            if (csr_we && csr_num == CSR_ESTAT) begin
                estat_is[1:0] <= estat_wdata[1:0];   // soft ints
            end
            estat_is[9:2] <= hw_int_in;
            estat_is[10]  <= 1'b0;
            if (is_timer) begin
                estat_is[11] <= 1'b1;   // new tick wins over a clear
            end else if (ticlr_clr) begin
                estat_is[11] <= 1'b0;
            end
            estat_is[12] <= ipi_int_in;
        end
    end

    // exception record
    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_ecode    <= 6'b0;
            estat_esubcode <= 9'b0;
            era            <= 32'b0;
            badv           <= 32'b0;
        end else if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
            era            <= wb_pc;
            if (badv_load) begin
                badv <= (wb_ecode == ECODE_ADE && wb_esubcode == ESUBCODE_ADEF) ? wb_pc : wb_vaddr;
            end
        end else if (csr_we && csr_num == CSR_ERA) begin
            era <= csr_merge(era, wmask, wvalue);
        end else if (csr_we && csr_num == CSR_BADV) begin
            badv <= csr_merge(badv, wmask, wvalue);
        end
    end

    // plain software registers
    always_ff @(posedge clk) begin
        if (!resetn) begin
            eentry_va <= '0;
            tid       <= 32'b0;
            for (int i = 0; i < 4; i++) begin
                save_data[i] <= 32'b0;
            end
        end else if (csr_we) begin
            if (csr_num == CSR_EENTRY) begin
                eentry_va <= eentry_wdata[31:EENTRY_VA_LSB];
            end
            if (csr_num == CSR_TID) begin
                tid <= csr_merge(tid, wmask, wvalue);
            end
            if (csr_num[CSR_NUM_W-1:2] == CSR_SAVE0[CSR_NUM_W-1:2]) begin   // 0x30..0x33
                save_data[csr_num[1:0]] <= csr_merge(save_data[csr_num[1:0]], wmask, wvalue);
            end
        end
    end

    always_comb begin
        case (csr_num)
            CSR_CRMD:   rvalue = crmd_rvalue;
            CSR_PRMD:   rvalue = prmd_rvalue;
            CSR_ECFG:   rvalue = ecfg_rvalue;
            CSR_ESTAT:  rvalue = estat_rvalue;
            CSR_ERA:    rvalue = era;
            CSR_BADV:   rvalue = badv;
            CSR_EENTRY: rvalue = eentry;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                        rvalue = save_data[csr_num[1:0]];
            CSR_TID:    rvalue = tid;
            CSR_TCFG, CSR_TVAL, CSR_TICLR:
                        rvalue = timer_rvalue;   // timer owns these
            default:    rvalue = 32'b0;
        endcase
    end

    a_lie_reserved: assert property (@(posedge clk) disable iff (!resetn)
        ecfg_lie[10] == 1'b0)
        else $error("csr_file: ECFG.LIE bit 10 set");

endmodule

/* logic/csr_timer.sv */
// TCFG/TVAL timer; counts initial value times four down to zero, TICLR reads back as zero
`timescale 1ns/1ps

module csr_timer import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 csr_we,
    input  logic [CSR_NUM_W-1:0] csr_num,
    input  logic [31:0]          wmask,
    input  logic [31:0]          wvalue,
    output logic [31:0]          timer_rvalue,
    output logic                 is_timer
);

    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    logic [31:0] timer_cnt;
    logic        tcfg_we;
    logic [31:0] tcfg_cur;
    logic [31:0] tcfg_next;

    assign tcfg_cur  = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_we   = csr_we && csr_num == CSR_TCFG;
    assign tcfg_next = csr_merge(tcfg_cur, wmask, wvalue);

    // one cycle pulse, the counter leaves zero on the next edge
    assign is_timer = tcfg_en && timer_cnt == 32'b0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= 30'b0;
            timer_cnt     <= TIMER_IDLE;
        end else if (tcfg_we) begin
            tcfg_en       <= tcfg_next[TCFG_EN_BIT];
            tcfg_periodic <= tcfg_next[TCFG_PERIODIC_BIT];
            tcfg_initval  <= tcfg_next[31:2];
            if (tcfg_next[TCFG_EN_BIT]) begin
                timer_cnt <= {tcfg_next[31:2], 2'b00};   // restart on enable
            end
        end else if (tcfg_en && timer_cnt != TIMER_IDLE) begin
            if (timer_cnt == 32'b0) begin
                timer_cnt <= tcfg_periodic ? {tcfg_initval, 2'b00} : TIMER_IDLE;
            end else begin
                timer_cnt <= timer_cnt - 32'd1;
            end
        end
    end

    always_comb begin
        case (csr_num)
            CSR_TCFG: timer_rvalue = tcfg_cur;
            CSR_TVAL: timer_rvalue = timer_cnt;
            default:  timer_rvalue = 32'b0;
        endcase
    end

    a_cnt_frozen: assert property (@(posedge clk) disable iff (!resetn)
        (!tcfg_en && !tcfg_we) |=> $stable(timer_cnt))
        else $error("csr_timer: counter moved while disabled");

endmodule

/* logic/csr_redirect.sv */
// pipeline redirect and interrupt request; exception beats ertn, target is zero when no flush
`timescale 1ns/1ps

module csr_redirect import csr_pkg::*; (
    input  logic        wb_ex,
    input  logic        ertn,
    input  logic [31:0] eentry,
    input  logic [31:0] era,
    input  logic [12:0] estat_is,
    input  logic [12:0] ecfg_lie,
    input  logic        crmd_ie,
    output logic        flush,
    output logic [31:0] flush_target,
    output logic        int_req
);

    logic [12:0] pending;

    assign pending = estat_is & ecfg_lie;   // enabled and raised

    always_comb begin
        flush = wb_ex || ertn;

        if (wb_ex) begin
            flush_target = eentry;          // exception entry
        end else if (ertn) begin
            flush_target = era;             // return address
        end else begin
            flush_target = 32'b0;
        end

        // global enable gates every line
        int_req = crmd_ie && (|pending);

        // eentry comes from the csr file with its low bits tied off
        if (wb_ex) begin
            assert (flush_target[EENTRY_VA_LSB-1:0] == '0)
                else $error("csr_redirect: unaligned exception target %h", flush_target);
        end
    end

endmodule

/* logic/csr_unit.sv */
// CSR unit top; one instruction per cycle, no back-pressure, rf_we is high for every CSR op
`timescale 1ns/1ps

module csr_unit import csr_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        inst_valid,
    input  logic [31:0] inst,
    input  logic [31:0] rj_data,
    input  logic [31:0] rd_data,
    input  logic        wb_ex,
    input  logic [5:0]  wb_ecode,
    input  logic [8:0]  wb_esubcode,
    input  logic [31:0] wb_pc,
    input  logic [31:0] wb_vaddr,
    input  logic [7:0]  hw_int_in,
    input  logic        ipi_int_in,
    output logic        rf_we,
    output logic [31:0] rf_wdata,
    output logic        flush,
    output logic [31:0] flush_target,
    output logic        int_req
);

    csr_op_t              op;
    logic [CSR_NUM_W-1:0] csr_num;
    logic                 ertn;
    logic                 csr_we;
    logic [31:0]          wmask;
    logic [31:0]          wvalue;
    logic [31:0]          timer_rvalue;
    logic                 is_timer;
    logic [31:0]          eentry;
    logic [31:0]          era;
    logic [12:0]          estat_is;
    logic [12:0]          ecfg_lie;
    logic                 crmd_ie;

    assign rf_we = op != OP_NONE;   // old value goes back for rd, wr and xchg

    csr_inst_decode u_decode (
        .inst_valid (inst_valid),
        .inst       (inst),
        .op         (op),
        .csr_num    (csr_num),
        .ertn       (ertn)
    );

    csr_file u_file (
        .clk          (clk),
        .resetn       (resetn),
        .op           (op),
        .csr_num      (csr_num),
        .rj_data      (rj_data),
        .rd_data      (rd_data),
        .ertn         (ertn),
        .wb_ex        (wb_ex),
        .wb_ecode     (wb_ecode),
        .wb_esubcode  (wb_esubcode),
        .wb_pc        (wb_pc),
        .wb_vaddr     (wb_vaddr),
        .hw_int_in    (hw_int_in),
        .ipi_int_in   (ipi_int_in),
        .timer_rvalue (timer_rvalue),
        .is_timer     (is_timer),
        .csr_we       (csr_we),
        .wmask        (wmask),
        .wvalue       (wvalue),
        .rvalue       (rf_wdata),
        .eentry       (eentry),
        .era          (era),
        .estat_is     (estat_is),
        .ecfg_lie     (ecfg_lie),
        .crmd_ie      (crmd_ie)
    );

    csr_timer u_timer (
        .clk          (clk),
        .resetn       (resetn),
        .csr_we       (csr_we),
        .csr_num      (csr_num),
        .wmask        (wmask),
        .wvalue       (wvalue),
        .timer_rvalue (timer_rvalue),
        .is_timer     (is_timer)
    );

    csr_redirect u_redirect (
        .wb_ex        (wb_ex),
        .ertn         (ertn),
        .eentry       (eentry),
        .era          (era),
        .estat_is     (estat_is),
        .ecfg_lie     (ecfg_lie),
        .crmd_ie      (crmd_ie),
        .flush        (flush),
        .flush_target (flush_target),
        .int_req      (int_req)
    );

endmodule

/* verification/csr_unit_tb.sv */
// LFSR-driven testbench; shadow model covers only the CSRs it touches, TVAL checked for trend only
`timescale 1ns/1ps

module csr_unit_tb import csr_pkg::*; ();

    logic        clk;
    logic        resetn;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] rj_data;
    logic [31:0] rd_data;
    logic        wb_ex;
    logic [5:0]  wb_ecode;
    logic [8:0]  wb_esubcode;
    logic [31:0] wb_pc;
    logic [31:0] wb_vaddr;
    logic [7:0]  hw_int_in;
    logic        ipi_int_in;
    logic        rf_we;
    logic [31:0] rf_wdata;
    logic        flush;
    logic [31:0] flush_target;
    logic        int_req;

    logic [31:0]          lfsr_state;
    logic [31:0]          shadow [0:127];   // expected CSR contents, by number
    logic [CSR_NUM_W-1:0] rw_nums [0:8];
    logic                 check_en;
    logic                 exp_rf_we;
    logic                 chk_data;
    logic [31:0]          exp_rdata;
    logic                 exp_flush;
    logic [31:0]          exp_target;
    logic                 chk_int;
    logic                 exp_int;
    logic [31:0]          seen_rdata;       // last sampled outputs, read back on the falling edge
    logic                 seen_int;
    int                   err_cnt;
    int                   timeout_cnt;

    csr_unit u_csr_unit (.*);

    always #50 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] bits);
        int i;
        bits = 32'h0;
        for (i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [6:0] slot(input logic [CSR_NUM_W-1:0] num);
        slot = num[6:0];
    endfunction

    // writable bits per register, zero for anything not implemented
    function automatic logic [31:0] field_mask(input logic [CSR_NUM_W-1:0] num);
        case (num)
            CSR_CRMD, CSR_PRMD: field_mask = 32'h0000_0007;
            CSR_ECFG:           field_mask = {19'b0, ECFG_LIE_MASK};
            CSR_EENTRY:         field_mask = 32'hffff_ffc0;
            CSR_ERA, CSR_BADV, CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID, CSR_TCFG:
                                field_mask = 32'hffff_ffff;
            default:            field_mask = 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] ref_merge(input logic [CSR_NUM_W-1:0] num,
                                              input logic [31:0] old_value,
                                              input logic [31:0] mask,
                                              input logic [31:0] value);
        ref_merge = ((value & mask) | (old_value & ~mask)) & field_mask(num);
    endfunction

    function automatic logic [31:0] ref_read(input logic [CSR_NUM_W-1:0] num);
        ref_read = (num[13:7] == 7'b0) ? shadow[slot(num)] : 32'h0;
    endfunction

    function automatic logic ref_irq();
        ref_irq = shadow[slot(CSR_CRMD)][CRMD_IE_BIT]
                  && (|(shadow[slot(CSR_ESTAT)][12:0] & shadow[slot(CSR_ECFG)][12:0]));
    endfunction

    task automatic log_mismatch(input string what);
        err_cnt++;
        $display("ERR %0t: %s", $time, what);
    endtask

    task automatic csr_access(input csr_op_t kind, input logic [CSR_NUM_W-1:0] num,
                              input logic [31:0] mask, input logic [31:0] value,
                              input logic irq_check);
        logic [4:0]  rj;
        logic [31:0] bits;
        logic [31:0] eff_mask;
        take_bits(4, bits);
        case (kind)
            OP_RD:   rj = 5'd0;
            OP_WR:   rj = 5'd1;
            default: rj = {1'b1, bits[3:0]};   // any rj above 1 is xchg
        endcase
        eff_mask = (kind == OP_WR) ? 32'hffff_ffff : mask;
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = INST_CSR_MATCH | {8'h00, num, rj, 5'd4};
        rj_data    = mask;
        rd_data    = value;
        wb_ex      = 1'b0;
        exp_rf_we  = 1'b1;
        chk_data   = num != CSR_TVAL;
        exp_rdata  = ref_read(num);   // old value comes back
        exp_flush  = 1'b0;
        chk_int    = irq_check;
        exp_int    = ref_irq();
        if (kind != OP_RD && num[13:7] == 7'b0) begin
            shadow[slot(num)] = ref_merge(num, shadow[slot(num)], eff_mask, value);
            if (num == CSR_TICLR && eff_mask[0] && value[0]) begin
                shadow[slot(CSR_ESTAT)][11] = 1'b0;
            end
        end
    endtask

    task automatic raise_exception(input logic [5:0] ecode, input logic [8:0] esub,
                                   input logic [31:0] pc, input logic [31:0] vaddr);
        @(negedge clk);
        inst_valid  = 1'b0;
        wb_ex       = 1'b1;
        wb_ecode    = ecode;
        wb_esubcode = esub;
        wb_pc       = pc;
        wb_vaddr    = vaddr;
        exp_rf_we   = 1'b0;
        exp_flush   = 1'b1;
        exp_target  = shadow[slot(CSR_EENTRY)];
        chk_int     = 1'b0;
        shadow[slot(CSR_PRMD)]         = {29'b0, shadow[slot(CSR_CRMD)][2:0]};
        shadow[slot(CSR_CRMD)]         = 32'h0;   // PLV0, interrupts off
        shadow[slot(CSR_ERA)]          = pc;
        shadow[slot(CSR_ESTAT)][30:16] = {esub, ecode};
        if (ecode == ECODE_ALE) begin
            shadow[slot(CSR_BADV)] = vaddr;   // misaligned data address
        end else if (ecode == ECODE_ADE && esub == ESUBCODE_ADEF) begin
            shadow[slot(CSR_BADV)] = pc;      // fetch side fault
        end
    endtask

    task automatic ertn_return();
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = INST_ERTN;
        wb_ex      = 1'b0;
        exp_rf_we  = 1'b0;
        exp_flush  = 1'b1;
        exp_target = shadow[slot(CSR_ERA)];
        chk_int    = 1'b0;
        shadow[slot(CSR_CRMD)] = {29'b0, shadow[slot(CSR_PRMD)][2:0]};
    endtask

    task automatic drive_irq(input logic [7:0] hw, input logic ipi);
        @(negedge clk);
        inst_valid = 1'b0;
        wb_ex      = 1'b0;
        hw_int_in  = hw;
        ipi_int_in = ipi;
        exp_rf_we  = 1'b0;
        exp_flush  = 1'b0;
        chk_int    = 1'b0;
        shadow[slot(CSR_ESTAT)][9:2] = hw;   // visible one cycle later
        shadow[slot(CSR_ESTAT)][12]  = ipi;
    endtask

    // compare on the rising edge, before any register moves
    always @(posedge clk) begin
        seen_rdata = rf_wdata;
        seen_int   = int_req;
        if (check_en) begin
            assert (rf_we === exp_rf_we)
                else log_mismatch($sformatf("rf_we %b, expected %b", rf_we, exp_rf_we));
            if (exp_rf_we && chk_data) begin
                assert (rf_wdata === exp_rdata)
                    else log_mismatch($sformatf("rf_wdata %h, expected %h", rf_wdata, exp_rdata));
            end
            assert (flush === exp_flush)
                else log_mismatch($sformatf("flush %b, expected %b", flush, exp_flush));
            if (exp_flush) begin
                assert (flush_target === exp_target)
                    else log_mismatch($sformatf("flush_target %h, expected %h",
                                                flush_target, exp_target));
            end
            if (chk_int) begin
                assert (int_req === exp_int)
                    else log_mismatch($sformatf("int_req %b, expected %b", int_req, exp_int));
            end
        end
    end

    initial begin
        int          i;
        int          idx;
        int          init_val;
        int          limit;
        int          cycles;
        logic        fired;
        logic [31:0] bits;
        logic [31:0] mask;
        logic [31:0] value;
        logic [31:0] pc;
        logic [31:0] vaddr;
        logic [31:0] prev_tval;
        csr_op_t     kind;

        clk = 1'b0;
        resetn = 1'b0;
        inst_valid = 1'b0;
        inst = 32'h0;
        rj_data = 32'h0;
        rd_data = 32'h0;
        wb_ex = 1'b0;
        wb_ecode = 6'h0;
        wb_esubcode = 9'h0;
        wb_pc = 32'h0;
        wb_vaddr = 32'h0;
        hw_int_in = 8'h0;
        ipi_int_in = 1'b0;
        lfsr_state = 32'ha38b5dbe;
        err_cnt = 0;
        timeout_cnt = 0;
        check_en = 1'b0;
        exp_rf_we = 1'b0;
        chk_data = 1'b0;
        exp_rdata = 32'h0;
        exp_flush = 1'b0;
        exp_target = 32'h0;
        chk_int = 1'b1;   // int_req must stay low out of reset
        exp_int = 1'b0;
        seen_rdata = 32'h0;
        seen_int = 1'b0;
        for (i = 0; i < 128; i++) begin
            shadow[i] = 32'h0;
        end
        rw_nums = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_ERA,
                    CSR_EENTRY, CSR_ECFG, CSR_TID, 14'h003};   // last one is unimplemented

        @(negedge clk);
        check_en = 1'b1;
        repeat (9) @(negedge clk);
        resetn = 1'b1;

        // masked writes, each followed by a read back
        for (i = 0; i < 40; i++) begin
            take_bits(5, bits);
            idx  = int'(bits[3:0]) % 9;
            kind = bits[4] ? OP_XCHG : OP_WR;
            take_bits(32, mask);
            take_bits(32, value);
            csr_access(kind, rw_nums[idx], mask, value, 1'b0);
            csr_access(OP_RD, rw_nums[idx], 32'h0, 32'h0, 1'b0);
        end

        // exception entry and return
        for (i = 0; i < 3; i++) begin
            take_bits(32, value);
            take_bits(32, pc);
            take_bits(32, vaddr);
            csr_access(OP_WR, CSR_CRMD, 32'hffff_ffff, value, 1'b0);
            case (i)
                0:       raise_exception(ECODE_ADE, ESUBCODE_ADEF, pc, vaddr);
                1:       raise_exception(ECODE_ALE, 9'd0, pc, vaddr);
                default: raise_exception(6'h0b, 9'd0, pc, vaddr);   // syscall, BADV kept
            endcase
            csr_access(OP_RD, CSR_CRMD, 32'h0, 32'h0, 1'b0);
            csr_access(OP_RD, CSR_PRMD, 32'h0, 32'h0, 1'b0);
            csr_access(OP_RD, CSR_ERA, 32'h0, 32'h0, 1'b0);
            csr_access(OP_RD, CSR_BADV, 32'h0, 32'h0, 1'b0);
            csr_access(OP_RD, CSR_ESTAT, 32'h0, 32'h0, 1'b0);
            ertn_return();
            csr_access(OP_RD, CSR_CRMD, 32'h0, 32'h0, 1'b0);
        end

        // interrupt sampling and masking
        for (i = 0; i < 12; i++) begin
            take_bits(23, bits);
            drive_irq(bits[7:0], bits[8]);
            csr_access(OP_WR, CSR_ECFG, 32'hffff_ffff, {19'b0, bits[21:9]}, 1'b0);
            csr_access(OP_WR, CSR_CRMD, 32'hffff_ffff, {29'b0, bits[22], 2'b00}, 1'b0);
            csr_access(OP_RD, CSR_ESTAT, 32'h0, 32'h0, 1'b1);
        end

        // one-shot timer, only LIE bit 11 enabled
        drive_irq(8'h00, 1'b0);
        csr_access(OP_WR, CSR_ECFG, 32'hffff_ffff, 32'h0000_0800, 1'b0);
        csr_access(OP_WR, CSR_CRMD, 32'hffff_ffff, 32'h0000_0004, 1'b0);
        take_bits(3, bits);
        init_val = int'(bits[2:0]) + 1;
        limit    = 4 * init_val + 3;
        value    = (32'(init_val) << 2) | 32'h1;   // enabled, not periodic
        csr_access(OP_WR, CSR_TCFG, 32'hffff_ffff, value, 1'b0);
        cycles    = 0;
        fired     = 1'b0;
        prev_tval = TIMER_IDLE;
        while (!fired && cycles < limit) begin
            csr_access(OP_RD, CSR_TVAL, 32'h0, 32'h0, 1'b0);
            cycles++;
            if (cycles >= 2 && seen_rdata != TIMER_IDLE) begin
                assert (seen_rdata <= prev_tval)
                    else log_mismatch($sformatf("TVAL rose from %h to %h", prev_tval, seen_rdata));
                prev_tval = seen_rdata;
            end
            fired = seen_int;
        end
        if (!fired) begin
            timeout_cnt++;
            $display("timeout: timer interrupt not seen within %0d cycles of the TCFG write",
                     limit);
        end else begin
            shadow[slot(CSR_ESTAT)][11] = 1'b1;
        end
        csr_access(OP_RD, CSR_ESTAT, 32'h0, 32'h0, 1'b1);
        csr_access(OP_WR, CSR_TICLR, 32'hffff_ffff, 32'h1, 1'b0);
        csr_access(OP_RD, CSR_ESTAT, 32'h0, 32'h0, 1'b1);
        csr_access(OP_RD, CSR_TCFG, 32'h0, 32'h0, 1'b0);

        drive_irq(8'h00, 1'b0);
        @(negedge clk);
        $display("run complete: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* build.f */
logic/csr_pkg.sv
logic/csr_inst_decode.sv
logic/csr_file.sv
logic/csr_timer.sv
logic/csr_redirect.sv
logic/csr_unit.sv
verification/csr_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -f build.f --top-module csr_unit_tb \
    -Mdir obj_dir -o csr_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/csr_unit_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
